// File: verification/soc_golden.dat
# op addr_or_sel data mask
# W host write (mask = byte strobes), R host read (mask = compare bits), D debug push, B buttons
W 40000010 11223344 f
W 40000010 aabbccdd 5
R 40000010 11bb33dd ffffffff
D 1 40000100 0
D 0 a1b2c3d4 0
D 0 55aa55aa 0
D 0 0badf00d 0
R 40000100 a1b2c3d4 ffffffff
R 40000104 55aa55aa ffffffff
R 40000108 0badf00d ffffffff
W 2000003c 00000f0f f
W 20000044 00f000f0 f
R 2000003c 00f00fff 3fffffff
W 20000048 00000303 f
R 2000003c 00f00cfc 3fffffff
W 20000000 0000beef f
B 0 0000005a 0
R 20000004 000000a5 ffffffff
R 90000000 deadbeef ffffffff
R 20000008 00010000 ffffffff
R 20000030 00000000 ffffffff
W 2000002c 00000001 f
R 2000002c 00000001 ffffffff
W 2000002c d0f1a501 f

// File: soc_mini.f
source/soc_bus_pkg.sv
source/soc_misc_pkg.sv
source/dbg_loader.sv
source/bus_arbiter.sv
source/bus_decoder.sv
source/word_ram.sv
source/misc_regs.sv
source/soc_top.sv
verification/soc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the soc_mini testbench with Verilator, run it and check the log
rm -f sim.log
verilator --binary --timing --assert --top-module soc_tb -f soc_mini.f -o soc_sim \
	&& ./obj_dir/soc_sim > sim.log 2>&1 \
	|| echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "^ALL CHECKS PASSED$" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: verification/soc_tb.sv
/* testbench for soc_top: replays the golden file through the host and debug
   ports and checks read data, interrupts, GPIO, LED and flash-select outputs */
`timescale 1ns/1ns

module soc_tb
	import soc_misc_pkg::*;
;

	// region nibbles and register indices as given by the address map
	localparam logic [3:0] MISC_REGION = 4'h2;
	localparam logic [3:0] RAM_REGION = 4'h4;
	localparam logic [4:0] LED_IDX = 5'd0;
	localparam logic [4:0] FLASH_SEL_IDX = 5'd11;
	localparam logic [4:0] GENIO_OUT_IDX = 5'd15;
	localparam logic [4:0] GENIO_OE_IDX = 5'd16;
	localparam logic [23:0] KEY_VALUE = 24'hd0f1a5;

	logic clk48m;
	logic rst;
	logic host_valid;
	logic [31:0] host_addr;
	logic [31:0] host_wdata;
	logic [3:0] host_wstrb;
	logic [31:0] host_rdata;
	logic host_ready;
	logic dbg_strobe;
	logic dbg_sel;
	logic [31:0] dbg_data;
	logic [7:0] btn;
	logic [15:0] led;
	logic [GENIO_W-1:0] genio_in;
	logic [GENIO_W-1:0] genio_out;
	logic [GENIO_W-1:0] genio_oe;
	logic fsel_c;
	logic fsel_d;
	logic programn;
	logic irq_bus_error;

	// golden file contents, one entry per line
	logic [7:0] op_q[$];
	logic [31:0] addr_q[$];
	logic [31:0] data_q[$];
	logic [31:0] mask_q[$];

	int seed = 15266;
	int cycle_limit = 0;
	logic reload_expected;
	// last value written to the output-enable register
	logic [GENIO_W-1:0] genio_oe_expected;

	soc_top u_dut (
		.clk48m(clk48m), .rst(rst),
		.host_valid(host_valid), .host_addr(host_addr), .host_wdata(host_wdata),
		.host_wstrb(host_wstrb), .host_rdata(host_rdata), .host_ready(host_ready),
		.dbg_strobe(dbg_strobe), .dbg_sel(dbg_sel), .dbg_data(dbg_data),
		.btn(btn), .led(led),
		.genio_in(genio_in), .genio_out(genio_out), .genio_oe(genio_oe),
		.fsel_c(fsel_c), .fsel_d(fsel_d), .programn(programn),
		.irq_bus_error(irq_bus_error)
	);

	initial begin
		clk48m = 1'b0;
		forever #50 clk48m = ~clk48m;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_failed(input string what);
		abort_run($sformatf("CHECK FAILED at %0t ns: %s", $time, what));
	endtask

	task automatic load_golden();
		int fd;
		int fields;
		string line;
		logic [7:0] op;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] m;
		fd = $fopen("verification/soc_golden.dat", "r");
		if (fd == 0) begin
			abort_run("could not open the golden file verification/soc_golden.dat");
		end
		while ($fgets(line, fd) != 0) begin
			// skip blank lines and comment lines
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			fields = $sscanf(line, "%c %h %h %h", op, a, d, m);
			if (fields != 4) begin
				abort_run($sformatf("golden file line is malformed: %s", line));
			end
			op_q.push_back(op);
			addr_q.push_back(a);
			data_q.push_back(d);
			mask_q.push_back(m);
		end
		$fclose(fd);
	endtask

	// one bus transfer on the host port, waits for host_ready
	task automatic host_access(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb, output logic [31:0] rdata);
		@(posedge clk48m);
		host_valid <= 1'b1;
		host_addr <= addr;
		host_wdata <= wdata;
		host_wstrb <= wstrb;
		@(negedge clk48m);
		while (!host_ready) begin
			@(negedge clk48m);
		end
		rdata = host_rdata;
		@(posedge clk48m);
		host_valid <= 1'b0;
		host_wstrb <= 4'h0;
	endtask

	// observes the side outputs for 10 cycles after a transfer
	task automatic watch_outputs(output int irq_pulses, output int fsel_c_cycles,
			output int programn_fall);
		irq_pulses = 0;
		fsel_c_cycles = 0;
		programn_fall = 0;
		for (int i = 1; i <= 10; i++) begin
			@(negedge clk48m);
			if (irq_bus_error) begin
				irq_pulses++;
			end
			if (fsel_c) begin
				fsel_c_cycles++;
			end
			if (!programn && programn_fall == 0) begin
				programn_fall = i;
			end
		end
	endtask

	task automatic run_host_op(input int n);
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] mask;
		logic [31:0] rdata;
		logic is_write;
		logic unmapped;
		logic flash_wr;
		logic led_wr;
		logic oe_wr;
		logic out_rd;
		int gap;
		int irq_pulses;
		int fsel_c_cycles;
		int programn_fall;
		addr = addr_q[n];
		data = data_q[n];
		mask = mask_q[n];
		is_write = (op_q[n] == "W");
		unmapped = (addr[31:28] != MISC_REGION) && (addr[31:28] != RAM_REGION);
		flash_wr = is_write && addr[31:28] == MISC_REGION && addr[6:2] == FLASH_SEL_IDX
			&& mask[0];
		led_wr = is_write && addr[31:28] == MISC_REGION && addr[6:2] == LED_IDX && mask[0];
		oe_wr = is_write && addr[31:28] == MISC_REGION && addr[6:2] == GENIO_OE_IDX
			&& mask[0];
		out_rd = !is_write && addr[31:28] == MISC_REGION && addr[6:2] == GENIO_OUT_IDX;
		// random idle time on the host side
		gap = $random(seed) & 3;
		repeat (gap) @(posedge clk48m);
		host_access(addr, is_write ? data : 32'h0, is_write ? mask[3:0] : 4'h0, rdata);
		watch_outputs(irq_pulses, fsel_c_cycles, programn_fall);
		if (!is_write) begin
			assert ((rdata & mask) == (data & mask)) else
				check_failed($sformatf("read %h at %h, expected %h under mask %h",
					rdata, addr, data, mask));
		end
		assert (irq_pulses == (unmapped ? 1 : 0)) else
			check_failed($sformatf("%0d bus error pulses after access to %h",
				irq_pulses, addr));
		assert (fsel_c_cycles == (flash_wr ? 3 : 0)) else
			check_failed($sformatf("fsel_c high for %0d cycles after access to %h",
				fsel_c_cycles, addr));
		if (flash_wr && data[31:8] == KEY_VALUE) begin
			assert (programn_fall >= 1 && programn_fall <= 8) else
				check_failed($sformatf("programn fell at cycle %0d after keyed write",
					programn_fall));
			reload_expected = 1'b1;
		end
		assert (programn == !reload_expected) else
			check_failed($sformatf("programn is %b after access to %h", programn, addr));
		if (flash_wr) begin
			assert (fsel_d == data[0]) else
				check_failed($sformatf("fsel_d is %b, written %b", fsel_d, data[0]));
		end
		if (led_wr) begin
			assert (led == data[15:0]) else
				check_failed($sformatf("led is %h, written %h", led, data[15:0]));
		end
		// output pins must match the register contents read back
		if (out_rd) begin
			assert (genio_out == data[GENIO_W-1:0]) else
				check_failed($sformatf("genio_out is %h, expected %h",
					genio_out, data[GENIO_W-1:0]));
		end
		if (oe_wr) begin
			genio_oe_expected = data[GENIO_W-1:0];
		end
		assert (genio_oe == genio_oe_expected) else
			check_failed($sformatf("genio_oe is %h, expected %h after access to %h",
				genio_oe, genio_oe_expected, addr));
	endtask

	initial begin : main
		int pushed;
		pushed = 0;
		rst = 1'b1;
		host_valid = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		host_wstrb = '0;
		dbg_strobe = 1'b0;
		dbg_sel = 1'b0;
		dbg_data = '0;
		btn = '0;
		genio_in = 30'h2aaa5555;
		reload_expected = 1'b0;
		genio_oe_expected = '0;
		load_golden();
		cycle_limit = 64 * op_q.size();
		repeat (5) @(posedge clk48m);
		rst <= 1'b0;
		for (int n = 0; n < op_q.size(); n++) begin
			// end of a debug burst, give the loader 4 cycles per entry
			if (op_q[n] != "D" && pushed > 0) begin
				@(posedge clk48m);
				dbg_strobe <= 1'b0;
				repeat (4 * pushed) @(posedge clk48m);
				pushed = 0;
			end
			case (op_q[n])
				"D": begin
					@(posedge clk48m);
					dbg_strobe <= 1'b1;
					dbg_sel <= addr_q[n][0];
					dbg_data <= data_q[n];
					pushed++;
				end
				"B": begin
					@(posedge clk48m);
					btn <= data_q[n][7:0];
				end
				"W", "R": run_host_op(n);
				default: abort_run($sformatf("unknown opcode %c in golden file", op_q[n]));
			endcase
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk48m);
			cycles++;
		end
		abort_run($sformatf("timeout: test did not finish within %0d cycles", cycle_limit));
	end

endmodule

// File: source/soc_top.sv
/* system-bus core of the badge SoC: host port and debug loader share
   the bus through the arbiter, decoder routes to RAM and misc registers */
`timescale 1ns/1ns

module soc_top
	import soc_bus_pkg::*;
	import soc_misc_pkg::*;
#(
	parameter int FIFO_DEPTH_LOG2 = 5,
	parameter int RAM_WORDS_LOG2 = 10
) (
	input logic clk48m,
	input logic rst,
	input logic host_valid,
	input addr_t host_addr,
	input data_t host_wdata,
	input strb_t host_wstrb,
	output data_t host_rdata,
	output logic host_ready,
	input logic dbg_strobe,
	input logic dbg_sel,
	input data_t dbg_data,
	input logic [7:0] btn,
	output logic [15:0] led,
	input logic [GENIO_W-1:0] genio_in,
	output logic [GENIO_W-1:0] genio_out,
	output logic [GENIO_W-1:0] genio_oe,
	output logic fsel_c,
	output logic fsel_d,
	output logic programn,
	output logic irq_bus_error
);

	// debug loader master
	logic dbg_valid;
	addr_t dbg_addr;
	data_t dbg_wdata;
	strb_t dbg_wstrb;
	logic dbg_ready;

	// shared bus
	logic bus_valid;
	addr_t bus_addr;
	data_t bus_wdata;
	strb_t bus_wstrb;
	data_t bus_rdata;
	logic bus_ready;

	logic ram_sel, ram_ready;
	logic misc_sel, misc_ready;
	data_t ram_rdata, misc_rdata;

	dbg_loader #(
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
	) u_loader (
		.clk48m(clk48m), .rst(rst),
		.dbg_strobe(dbg_strobe), .dbg_sel(dbg_sel), .dbg_data(dbg_data),
		.m_valid(dbg_valid), .m_addr(dbg_addr), .m_wdata(dbg_wdata),
		.m_wstrb(dbg_wstrb), .m_ready(dbg_ready)
	);

	bus_arbiter u_arb (
		.clk48m(clk48m), .rst(rst),
		.h_valid(host_valid), .h_addr(host_addr), .h_wdata(host_wdata),
		.h_wstrb(host_wstrb), .h_rdata(host_rdata), .h_ready(host_ready),
		.d_valid(dbg_valid), .d_addr(dbg_addr), .d_wdata(dbg_wdata),
		.d_wstrb(dbg_wstrb), .d_ready(dbg_ready),
		.bus_valid(bus_valid), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
		.bus_wstrb(bus_wstrb), .bus_rdata(bus_rdata), .bus_ready(bus_ready)
	);

	bus_decoder u_dec (
		.clk48m(clk48m), .rst(rst),
		.bus_valid(bus_valid), .bus_addr(bus_addr),
		.bus_rdata(bus_rdata), .bus_ready(bus_ready),
		.ram_sel(ram_sel), .misc_sel(misc_sel),
		.ram_rdata(ram_rdata), .misc_rdata(misc_rdata),
		.ram_ready(ram_ready), .misc_ready(misc_ready),
		.irq_bus_error(irq_bus_error)
	);

	word_ram #(
		.RAM_WORDS_LOG2(RAM_WORDS_LOG2)
	) u_ram (
		.clk48m(clk48m), .rst(rst),
		.sel(ram_sel), .addr(bus_addr), .wdata(bus_wdata), .wstrb(bus_wstrb),
		.rdata(ram_rdata), .ready(ram_ready)
	);

	misc_regs u_misc (
		.clk48m(clk48m), .rst(rst),
		.sel(misc_sel), .addr(bus_addr), .wdata(bus_wdata), .wstrb(bus_wstrb),
		.rdata(misc_rdata), .ready(misc_ready),
		.btn(btn), .led(led),
		.genio_in(genio_in), .genio_out(genio_out), .genio_oe(genio_oe),
		.fsel_c(fsel_c), .fsel_d(fsel_d), .programn(programn)
	);

endmodule

// File: source/misc_regs.sv
/* misc register block: led, buttons, version, general I/O and the
   flash-select register with its clock pulse and keyed FPGA reload */
`timescale 1ns/1ns

module misc_regs
	import soc_bus_pkg::*;
	import soc_misc_pkg::*;
(
	input logic clk48m,
	input logic rst,
	input logic sel,
	input addr_t addr,
	input data_t wdata,
	input strb_t wstrb,
	output data_t rdata,
	output logic ready,
	input logic [7:0] btn,
	output logic [15:0] led,
	input logic [GENIO_W-1:0] genio_in,
	output logic [GENIO_W-1:0] genio_out,
	output logic [GENIO_W-1:0] genio_oe,
	output logic fsel_c,
	output logic fsel_d,
	output logic programn
);

	misc_reg_t reg_idx;
	logic wr_en;
	logic [2:0] fsel_delay;
	logic reload_armed;
	logic fpga_reload;

	assign reg_idx = misc_reg_t'(addr[6:2]);
	assign wr_en = sel && wstrb[0];

	// registers answer in the same cycle
	assign ready = sel;

	always_comb begin
		case (reg_idx)
			MISC_REG_LED: rdata = {16'h0, led};
			// buttons are active low on the board
			MISC_REG_BTN: rdata = {24'h0, ~btn};
			MISC_REG_SOC_VER: rdata = SOC_VERSION;
			MISC_REG_FLASH_SEL: rdata = {31'h0, fsel_d};
			MISC_REG_GENIO_IN: rdata = {{(32-GENIO_W){1'b0}}, genio_in};
			MISC_REG_GENIO_OUT: rdata = {{(32-GENIO_W){1'b0}}, genio_out};
			MISC_REG_GENIO_OE: rdata = {{(32-GENIO_W){1'b0}}, genio_oe};
			default: rdata = '0;
		endcase
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led <= '0;
			genio_out <= '0;
			genio_oe <= '0;
			fsel_d <= 1'b0;
			reload_armed <= 1'b0;
		end else if (wr_en) begin
			case (reg_idx)
				MISC_REG_LED: led <= wdata[15:0];
				MISC_REG_FLASH_SEL: begin
					fsel_d <= wdata[0];
					reload_armed <= (wdata[31:8] == RELOAD_KEY);
				end
				MISC_REG_GENIO_OUT: genio_out <= wdata[GENIO_W-1:0];
				MISC_REG_GENIO_OE: genio_oe <= wdata[GENIO_W-1:0];
				MISC_REG_GENIO_W2S: genio_out <= genio_out | wdata[GENIO_W-1:0];
				MISC_REG_GENIO_W2C: genio_out <= genio_out & ~wdata[GENIO_W-1:0];
				default: ;
			endcase
		end
	end

	// countdown gives fsel_d time to settle before the clock edge
	// and before programn is pulled
	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_delay <= '0;
			fpga_reload <= 1'b0;
		end else if (wr_en && reg_idx == MISC_REG_FLASH_SEL) begin
			fsel_delay <= 3'(FSEL_DELAY);
		end else if (fsel_delay != 0) begin
			fsel_delay <= fsel_delay - 1'b1;
			if (fsel_delay == 3'd1 && reload_armed) begin
				fpga_reload <= 1'b1;
			end
		end
	end

	assign fsel_c = (fsel_delay >= 3'd3) && (fsel_delay <= 3'd5);
	assign programn = ~fpga_reload;

endmodule

// File: source/word_ram.sv
/* on-chip word RAM for the RAM region, byte write strobes,
   answers one cycle after select */
`timescale 1ns/1ns

module word_ram
	import soc_bus_pkg::*;
#(
	parameter int RAM_WORDS_LOG2 = 10
) (
	input logic clk48m,
	input logic rst,
	input logic sel,
	input addr_t addr,
	input data_t wdata,
	input strb_t wstrb,
	output data_t rdata,
	output logic ready
);

	logic [31:0] mem [2 ** RAM_WORDS_LOG2];
	logic [RAM_WORDS_LOG2-1:0] word_idx;
	logic access;

	assign word_idx = addr[RAM_WORDS_LOG2+1:2];

	// select stays high during the ready cycle, so only the first cycle counts
	assign access = sel && !ready;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			ready <= 1'b0;
		end else begin
			ready <= access;
		end
	end

	always_ff @(posedge clk48m) begin
		if (access) begin
			rdata <= mem[word_idx];
			for (int b = 0; b < 4; b++) begin
				if (wstrb[b]) begin
					mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

// File: source/bus_decoder.sv
/* region decoder: slave selects, read data mux and merged ready;
   unmapped accesses complete at once and raise the bus error interrupt */
`timescale 1ns/1ns

module bus_decoder
	import soc_bus_pkg::*;
(
	input logic clk48m,
	input logic rst,
	input logic bus_valid,
	input addr_t bus_addr,
	output data_t bus_rdata,
	output logic bus_ready,
	output logic ram_sel,
	output logic misc_sel,
	input data_t ram_rdata,
	input data_t misc_rdata,
	input logic ram_ready,
	input logic misc_ready,
	output logic irq_bus_error
);

	region_t region;
	logic bus_error;

	assign region = region_t'(bus_addr[31:28]);

	always_comb begin
		ram_sel = 1'b0;
		misc_sel = 1'b0;
		bus_error = 1'b0;
		case (region)
			REGION_MISC: begin
				misc_sel = bus_valid;
				bus_rdata = misc_rdata;
			end
			REGION_RAM: begin
				ram_sel = bus_valid;
				bus_rdata = ram_rdata;
			end
			default: begin
				// nothing decodes here, answer immediately
				bus_error = bus_valid;
				bus_rdata = BUS_ERROR_DATA;
			end
		endcase
	end

	assign bus_ready = ram_ready || misc_ready || bus_error;

	// one-cycle interrupt pulse, one cycle behind the errored access
	always_ff @(posedge clk48m) begin
		if (rst) begin
			irq_bus_error <= 1'b0;
		end else begin
			irq_bus_error <= bus_error;
		end
	end

endmodule

// File: source/bus_arbiter.sv
/* two-master arbiter for the system bus; host is master 0, debug loader
   is master 1, the grant is registered and held until ready */
`timescale 1ns/1ns

module bus_arbiter
	import soc_bus_pkg::*;
(
	input logic clk48m,
	input logic rst,
	input logic h_valid,
	input addr_t h_addr,
	input data_t h_wdata,
	input strb_t h_wstrb,
	output data_t h_rdata,
	output logic h_ready,
	input logic d_valid,
	input addr_t d_addr,
	input data_t d_wdata,
	input strb_t d_wstrb,
	output logic d_ready,
	output logic bus_valid,
	output addr_t bus_addr,
	output data_t bus_wdata,
	output strb_t bus_wstrb,
	input data_t bus_rdata,
	input logic bus_ready
);

	logic busy;
	logic grant;
	logic last_winner;
	logic contention;
	logic winner;

	assign contention = h_valid && d_valid;

	// under contention the loser of the last contest goes first
	assign winner = contention ? ~last_winner : d_valid;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			busy <= 1'b0;
			grant <= 1'b0;
			last_winner <= 1'b1;
		end else if (busy) begin
			if (bus_ready) begin
				busy <= 1'b0;
			end
		end else if (h_valid || d_valid) begin
			busy <= 1'b1;
			grant <= winner;
			if (contention) begin
				last_winner <= winner;
			end
		end
	end

	assign bus_valid = busy && (grant ? d_valid : h_valid);
	assign bus_addr = grant ? d_addr : h_addr;
	assign bus_wdata = grant ? d_wdata : h_wdata;
	assign bus_wstrb = grant ? d_wstrb : h_wstrb;

	// response goes back to the owner only
	assign h_ready = busy && !grant && bus_ready;
	assign d_ready = busy && grant && bus_ready;
	assign h_rdata = grant ? '0 : bus_rdata;

endmodule

// File: source/dbg_loader.sv
/* debug register loader: queues address/data words from the debug port
   and replays them as full-word bus writes to consecutive addresses */
`timescale 1ns/1ns

module dbg_loader
	import soc_bus_pkg::*;
#(
	parameter int FIFO_DEPTH_LOG2 = 5
) (
	input logic clk48m,
	input logic rst,
	input logic dbg_strobe,
	input logic dbg_sel,
	input data_t dbg_data,
	output logic m_valid,
	output addr_t m_addr,
	output data_t m_wdata,
	output strb_t m_wstrb,
	input logic m_ready
);

	localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

	// bit 32 is the tag, set for an address word
	logic [32:0] fifo_mem [DEPTH];
	logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
	logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
	logic fifo_empty;
	logic pop;
	logic [32:0] head;

	assign fifo_empty = (wr_ptr == rd_ptr);
	assign head = fifo_mem[rd_ptr];

	// a push wins over a pop, and nothing is popped while a write is pending
	assign pop = !dbg_strobe && !m_valid && !fifo_empty;

	// loader only ever writes whole words
	assign m_wstrb = 4'hf;

	always_ff @(posedge clk48m) begin
		if (dbg_strobe) begin
			fifo_mem[wr_ptr] <= {dbg_sel, dbg_data};
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			m_valid <= 1'b0;
			m_addr <= '0;
		end else begin
			if (dbg_strobe) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (m_valid && m_ready) begin
				m_valid <= 1'b0;
				m_addr <= m_addr + WORD_STEP;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				if (head[32]) begin
					m_addr <= head[31:0];
				end else begin
					m_valid <= 1'b1;
				end
			end
		end
	end

	// write data is held until the next data entry is popped
	always_ff @(posedge clk48m) begin
		if (pop && !head[32]) begin
			m_wdata <= head[31:0];
		end
	end

endmodule

// File: source/soc_misc_pkg.sv
/* register map and constants of the misc register block
   (led, buttons, version, general I/O, flash select) */
package soc_misc_pkg;

	// register index, taken from address bits 6:2
	typedef enum logic [4:0] {
		MISC_REG_LED = 5'd0,
		MISC_REG_BTN = 5'd1,
		MISC_REG_SOC_VER = 5'd2,
		MISC_REG_FLASH_SEL = 5'd11,
		MISC_REG_GENIO_IN = 5'd14,
		MISC_REG_GENIO_OUT = 5'd15,
		MISC_REG_GENIO_OE = 5'd16,
		MISC_REG_GENIO_W2S = 5'd17,
		MISC_REG_GENIO_W2C = 5'd18
	} misc_reg_t;

	localparam logic [31:0] SOC_VERSION = 32'h0001_0000;

	// upper 24 bits of a flash-select write that request an FPGA reload
	localparam logic [23:0] RELOAD_KEY = 24'hd0f1a5;

	localparam int GENIO_W = 30;

	// start value of the flash-select countdown
	localparam int FSEL_DELAY = 7;

endpackage

// File: source/soc_bus_pkg.sv
/* bus types, address regions and fixed bus values for the system bus
   and the modules hanging off it */
package soc_bus_pkg;

	// valid/ready bus, a zero write strobe marks a read
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] strb_t;

	// top address nibble, anything not listed is unmapped
	typedef enum logic [3:0] {
		REGION_MISC = 4'h2,
		REGION_RAM = 4'h4
	} region_t;

	// read data returned for an access to an unmapped region
	localparam data_t BUS_ERROR_DATA = 32'hdeadbeef;

	// byte increment between consecutive words
	localparam logic [31:0] WORD_STEP = 32'd4;

endpackage
